/* logic/fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// fetch types shared by the prefetch subsystem
// address, instruction word, loop count and fetch FSM encoding
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // byte address of an instruction, always word aligned here
  typedef logic [31:0] addr_t;

  // one instruction word as returned by the memory
  typedef logic [31:0] word_t;

  // remaining hardware-loop iterations
  typedef logic [15:0] lcount_t;

  // fetch FSM states
  // IDLE         nothing outstanding on the bus
  // WAIT_GNT     request driven, grant not seen yet
  // WAIT_RVALID  granted, waiting for the data beat
  // WAIT_ABORTED granted request was overtaken by a branch, drop its data
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage

/* logic/prefetch_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// prefetch control FSM
// drives the memory request, FIFO push/clear and the address latch
////////////////////////////////////////////////////////////////////////////

module prefetch_ctrl (
  input  logic clk,
  input  logic rst_n,

  input  logic req_i,
  input  logic branch_i,

  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,

  input  logic fifo_ready_i,
  input  logic loop_redirect_i,

  output logic instr_req_o,
  output logic addr_load_o,
  output logic fifo_push_o,
  output logic fifo_clear_o,
  output logic fetch_fire_o,
  output logic busy_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  fetch_state_e issue_state;

  logic can_issue;
  logic fire;
  // a branch target sits on the bus and has not been granted yet
  logic held_q;

  ////////////////////////////////////////////////////////////////////////////
  // request qualification
  ////////////////////////////////////////////////////////////////////////////

  // a branch always gets through because it clears the FIFO
  assign can_issue   = req_i & (fifo_ready_i | branch_i);
  assign fire        = instr_req_o & instr_gnt_i;
  // state after putting a request on the bus this cycle
  assign issue_state = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;

  // the address register follows every granted request
  assign addr_load_o  = fire;
  assign fifo_clear_o = branch_i;

  // only a granted loop-back fetch counts as one iteration
  // a replayed branch target is not a loop-back even at the loop end
  assign fetch_fire_o = fire & loop_redirect_i & ~held_q;

  assign busy_o = (state_q != IDLE) | instr_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    fifo_push_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (can_issue) begin
          instr_req_o = 1'b1;
          state_d     = issue_state;
        end
      end

      // hold the request until the memory takes it
      WAIT_GNT: begin
        instr_req_o = 1'b1;
        state_d     = issue_state;
      end

      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // data from before a same-cycle branch is stale
          fifo_push_o = ~branch_i;
          // overlap the next request with the data beat
          if (can_issue) begin
            instr_req_o = 1'b1;
            state_d     = issue_state;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // response still in flight, swallow it later
          state_d = WAIT_ABORTED;
        end
      end

      WAIT_ABORTED: begin
        // stale beat is dropped, new target goes out in the same cycle
        if (instr_rvalid_i) begin
          if (can_issue) begin
            instr_req_o = 1'b1;
            state_d     = issue_state;
          end else begin
            state_d = IDLE;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      held_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fire) begin
        held_q <= 1'b0;
      end else if (branch_i) begin
        held_q <= 1'b1;
      end
    end
  end

endmodule

/* logic/fetch_addr_gen.sv */
////////////////////////////////////////////////////////////////////////////
// fetch address generator
// last issued address and next-address select by branch, loop or sequence
////////////////////////////////////////////////////////////////////////////

module fetch_addr_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             loop_redirect_i,
  input  fetch_pkg::addr_t loop_start_i,
  input  logic             addr_load_i,
  output fetch_pkg::addr_t issue_addr_o,
  output fetch_pkg::addr_t pending_addr_o
);
  import fetch_pkg::*;

  addr_t last_addr_q;
  addr_t next_addr;
  // register holds a branch target that still has to be issued
  logic  reuse_q;

  // priority order is branch, held target, loop start, sequential
  always_comb begin
    if (branch_i) begin
      next_addr = branch_addr_i;
    end else if (reuse_q) begin
      next_addr = last_addr_q;
    end else if (loop_redirect_i) begin
      next_addr = loop_start_i;
    end else begin
      next_addr = last_addr_q + 32'd4;
    end
  end

  assign issue_addr_o   = next_addr;
  assign pending_addr_o = last_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_addr_q <= '0;
      reuse_q     <= 1'b0;
    end else begin
      // a branch takes the target even without a grant
      if (addr_load_i || branch_i) begin
        last_addr_q <= next_addr;
      end
      if (addr_load_i) begin
        reuse_q <= 1'b0;
      end else if (branch_i) begin
        reuse_q <= 1'b1;
      end
    end
  end

endmodule

/* logic/hwloop_unit.sv */
////////////////////////////////////////////////////////////////////////////
// single hardware loop
// start, end and count registers plus the loop-back decision
////////////////////////////////////////////////////////////////////////////

module hwloop_unit (
  input  logic               clk,
  input  logic               rst_n,

  // configuration from the core
  input  logic               hwlp_we_i,
  input  fetch_pkg::addr_t   hwlp_start_i,
  input  fetch_pkg::addr_t   hwlp_end_i,
  input  fetch_pkg::lcount_t hwlp_count_i,

  // fetch side
  input  fetch_pkg::addr_t   last_addr_i,
  input  logic               fetch_fire_i,
  input  logic               branch_i,

  output logic               loop_redirect_o,
  output fetch_pkg::addr_t   loop_start_o
);
  import fetch_pkg::*;

  addr_t   start_q;
  addr_t   end_q;
  lcount_t count_q;

  // jump back only while another pass through the body is owed
  // count 0 or 1 means the body runs once and falls through
  assign loop_redirect_o = (last_addr_i == end_q) && (count_q > 16'd1);
  assign loop_start_o    = start_q;

  // loop bounds load together with the count
  always_ff @(posedge clk) begin
    if (hwlp_we_i) begin
      start_q <= hwlp_start_i;
      end_q   <= hwlp_end_i;
    end
  end

  // count 0 after reset keeps the loop inactive
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (hwlp_we_i) begin
      count_q <= hwlp_count_i;
    end else if (fetch_fire_i && loop_redirect_o && !branch_i) begin
      // a branch in the same cycle wins over the loop-back fetch
      count_q <= count_q - 16'd1;
    end
  end

endmodule

/* logic/fetch_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// fetch FIFO of address/word pairs as a circular buffer with fill count
////////////////////////////////////////////////////////////////////////////

module fetch_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear_i,
  input  logic             push_i,
  input  fetch_pkg::addr_t push_addr_i,
  input  fetch_pkg::word_t push_data_i,
  input  logic             pop_i,
  output logic             ready_o,
  output logic             valid_o,
  output fetch_pkg::addr_t addr_o,
  output fetch_pkg::word_t data_o
);
  import fetch_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  addr_t addr_mem [FIFO_DEPTH];
  word_t data_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // a clear hides the head in its own cycle
  assign valid_o = (count_q != '0) && !clear_i;
  assign addr_o  = addr_mem[rd_ptr_q];
  assign data_o  = data_mem[rd_ptr_q];

  // room for the beat in flight plus one more request
  assign ready_o = count_q <= CNT_W'(FIFO_DEPTH - 2);

  assign do_push = push_i && !clear_i;
  assign do_pop  = valid_o && pop_i;

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      data_mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap by hand for depths that are not a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* logic/prefetch_top.sv */
////////////////////////////////////////////////////////////////////////////
// instruction prefetch top
// fetch FSM, address generator, hardware loop and fetch FIFO
////////////////////////////////////////////////////////////////////////////

module prefetch_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,

  // core side
  input  logic               req_i,
  input  logic               branch_i,
  input  fetch_pkg::addr_t   branch_addr_i,
  input  logic               ready_i,
  output logic               valid_o,
  output fetch_pkg::word_t   rdata_o,
  output fetch_pkg::addr_t   addr_o,
  output logic               busy_o,

  // loop configuration, written while req_i is low
  input  logic               hwlp_we_i,
  input  fetch_pkg::addr_t   hwlp_start_i,
  input  fetch_pkg::addr_t   hwlp_end_i,
  input  fetch_pkg::lcount_t hwlp_count_i,

  // instruction memory bus
  output logic               instr_req_o,
  input  logic               instr_gnt_i,
  output fetch_pkg::addr_t   instr_addr_o,
  input  fetch_pkg::word_t   instr_rdata_i,
  input  logic               instr_rvalid_i
);
  import fetch_pkg::*;

  logic  addr_load;
  logic  fifo_push;
  logic  fifo_clear;
  logic  fifo_ready;
  logic  fetch_fire;
  logic  loop_redirect;
  addr_t loop_start;
  addr_t pending_addr;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  prefetch_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .fifo_ready_i    (fifo_ready),
    .loop_redirect_i (loop_redirect),
    .instr_req_o     (instr_req_o),
    .addr_load_o     (addr_load),
    .fifo_push_o     (fifo_push),
    .fifo_clear_o    (fifo_clear),
    .fetch_fire_o    (fetch_fire),
    .busy_o          (busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  // issue address goes straight onto the bus
  fetch_addr_gen u_addr_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .loop_redirect_i (loop_redirect),
    .loop_start_i    (loop_start),
    .addr_load_i     (addr_load),
    .issue_addr_o    (instr_addr_o),
    .pending_addr_o  (pending_addr)
  );

  hwloop_unit u_hwloop (
    .clk             (clk),
    .rst_n           (rst_n),
    .hwlp_we_i       (hwlp_we_i),
    .hwlp_start_i    (hwlp_start_i),
    .hwlp_end_i      (hwlp_end_i),
    .hwlp_count_i    (hwlp_count_i),
    .last_addr_i     (pending_addr),
    .fetch_fire_i    (fetch_fire),
    .branch_i        (branch_i),
    .loop_redirect_o (loop_redirect),
    .loop_start_o    (loop_start)
  );

  // words are tagged with the address of the outstanding request
  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (fifo_clear),
    .push_i      (fifo_push),
    .push_addr_i (pending_addr),
    .push_data_i (instr_rdata_i),
    .pop_i       (ready_i),
    .ready_o     (fifo_ready),
    .valid_o     (valid_o),
    .addr_o      (addr_o),
    .data_o      (rdata_o)
  );

endmodule

/* dv/prefetch_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// bus and output assertions for the prefetch top
////////////////////////////////////////////////////////////////////////////

module prefetch_assertions #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                branch_i,
  input logic                                instr_req_i,
  input logic                                instr_gnt_i,
  input fetch_pkg::addr_t                    instr_addr_i,
  input logic                                valid_i,
  input logic                                fifo_push_i,
  input logic                                fifo_clear_i,
  input logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_count_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // ungranted request keeps its address unless a branch redirects it
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_i && !instr_gnt_i && !branch_i) |=>
      (instr_req_i && (branch_i || instr_addr_i == $past(instr_addr_i))))
    else $error("request dropped or address moved before grant");

  // clear takes effect one cycle after the branch
  branch_flush: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |=> !valid_i)
    else $error("valid_o high in the cycle after a branch");

  fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_count_i <= CNT_W'(FIFO_DEPTH))
    else $error("fetch FIFO fill count above depth");

  // a full FIFO must never see a real push
  fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (fifo_count_i == CNT_W'(FIFO_DEPTH)) |-> !(fifo_push_i && !fifo_clear_i))
    else $error("push into a full fetch FIFO");

endmodule

bind prefetch_top prefetch_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) u_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .branch_i     (branch_i),
  .instr_req_i  (instr_req_o),
  .instr_gnt_i  (instr_gnt_i),
  .instr_addr_i (instr_addr_o),
  .valid_i      (valid_o),
  .fifo_push_i  (fifo_push),
  .fifo_clear_i (fifo_clear),
  .fifo_count_i (u_fifo.count_q)
);

/* dv/prefetch_tb.sv */
////////////////////////////////////////////////////////////////////////////
// prefetch testbench with memory model, test-file reader, consumer and checks
////////////////////////////////////////////////////////////////////////////

module prefetch_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  localparam int FIFO_DEPTH = 4;

  logic clk, rst_n, req_i, branch_i, ready_i, valid_o, busy_o, hwlp_we_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  addr_t branch_addr_i, addr_o, hwlp_start_i, hwlp_end_i, instr_addr_o;
  word_t rdata_o, instr_rdata_i;
  lcount_t hwlp_count_i;

  int errors, checks, tests, gnt_cnt, rv_cnt, fd, code, gap, i;
  addr_t rv_addr;
  bit gaps, req_next, we_next, took;
  logic [7:0] kind;
  logic [31:0] f1, f2, f3, f4, f5, f6;
  addr_t last, a;
  word_t w;
  string line;

  prefetch_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // drive on the falling edge, answer as the memory, then sample the consumer side
  task automatic tick(input bit br, input addr_t tgt, output bit tk, output addr_t ta,
                      output word_t tw);
    @(negedge clk);
    req_i = req_next;
    hwlp_we_i = we_next;
    we_next = 1'b0;
    branch_i = br;
    branch_addr_i = tgt;
    ready_i = gaps ? ($urandom_range(2, 0) != 0) : 1'b1;
    instr_rvalid_i = 1'b0;
    if (rv_cnt > 0) begin
      rv_cnt--;
      if (rv_cnt == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i = ~rv_addr;
      end
    end
    #1;
    // grant after 0..3 cycles of request, data 1..3 cycles later
    instr_gnt_i = 1'b0;
    if (instr_req_o) begin
      if (gnt_cnt < 0) gnt_cnt = $urandom_range(3, 0);
      if (gnt_cnt == 0) begin
        instr_gnt_i = 1'b1;
        rv_cnt = $urandom_range(3, 1);
        rv_addr = instr_addr_o;
        gnt_cnt = -1;
      end else begin
        gnt_cnt--;
      end
    end
    #1;
    tk = valid_o && ready_i;
    ta = addr_o;
    tw = rdata_o;
  endtask

  // drop req_i, wait for an idle bus, load the loop and branch to the target
  task automatic start_test(input addr_t s, input addr_t e, input lcount_t c, input addr_t tgt);
    int t;
    req_next = 1'b0;
    t = 0;
    tick(1'b0, '0, took, a, w);
    while (busy_o && t < 100) begin
      tick(1'b0, '0, took, a, w);
      t++;
    end
    if (busy_o) begin
      $display("timeout: fetch stayed busy after req_i was dropped");
      errors++;
    end
    hwlp_start_i = s;
    hwlp_end_i = e;
    hwlp_count_i = c;
    we_next = 1'b1;
    tick(1'b0, '0, took, a, w);
    req_next = 1'b1;
    tick(1'b1, tgt, took, a, w);
    // branch from an idle bus puts the target out in its own cycle
    checks++;
    if (instr_req_o !== 1'b1 || busy_o !== 1'b1) begin
      $display("FAIL t=%0t instr_req_o/busy_o got %b%b exp 11", $time,
               instr_req_o, busy_o);
      errors++;
    end
    if (instr_addr_o !== tgt) begin
      $display("FAIL t=%0t instr_addr_o got %h exp %h", $time, instr_addr_o, tgt);
      errors++;
    end
  endtask

  // take n words and check each against the next-address rule
  task automatic take_words(input addr_t first, input int n, input addr_t s, input addr_t e,
                            input lcount_t c, output addr_t lst);
    addr_t exp;
    lcount_t rem;
    int got, t;
    exp = first;
    rem = c;
    got = 0;
    t = 0;
    lst = '0;
    while (got < n && t < 100 * n) begin
      tick(1'b0, '0, took, a, w);
      t++;
      if (took) begin
        checks++;
        if (a !== exp) begin
          $display("FAIL t=%0t addr_o got %h exp %h", $time, a, exp);
          errors++;
        end
        if (w !== ~exp) begin
          $display("FAIL t=%0t rdata_o got %h exp %h", $time, w, ~exp);
          errors++;
        end
        lst = a;
        got++;
        if (exp == e && rem > 16'd1) begin
          rem = rem - 16'd1;
          exp = s;
        end else begin
          exp = exp + 32'd4;
        end
      end
    end
    if (got < n) begin
      $display("timeout: only %0d of %0d words arrived", got, n);
      errors++;
    end
  endtask

  task automatic check_last(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t last addr_o got %h exp %h", $time, got, exp);
      errors++;
    end
  endtask

  initial begin
    void'($urandom(68545));
    errors = 0;
    checks = 0;
    tests = 0;
    gnt_cnt = -1;
    rv_cnt = 0;
    rv_addr = '0;
    gaps = 1'b0;
    req_next = 1'b0;
    we_next = 1'b0;
    rst_n = 1'b0;
    req_i = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = '0;
    ready_i = 1'b0;
    hwlp_we_i = 1'b0;
    hwlp_start_i = '0;
    hwlp_end_i = '0;
    hwlp_count_i = '0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // quiet bus until the first branch
    for (i = 0; i < 5; i++) begin
      tick(1'b0, '0, took, a, w);
      if (instr_req_o || valid_o || busy_o) begin
        $display("FAIL t=%0t req/valid/busy got %b%b%b exp 000", $time,
                 instr_req_o, valid_o, busy_o);
        errors++;
      end
    end
    fd = $fopen("dv/prefetch_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file dv/prefetch_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) break;
        // odd tests run the consumer with random ready gaps
        gaps = tests[0];
        if (kind == "B") begin
          code = $fscanf(fd, " %h %h %h", f1, f2, f3);
          start_test('0, '0, '0, f1);
          take_words(f1, int'(f2), '0, '0, '0, last);
          check_last(last, f3);
          tests++;
        end else if (kind == "L") begin
          code = $fscanf(fd, " %h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
          start_test(f1, f2, f3[15:0], f4);
          take_words(f4, int'(f5), f1, f2, f3[15:0], last);
          check_last(last, f6);
          tests++;
        end else if (kind == "X") begin
          code = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
          start_test('0, '0, '0, f1);
          for (gap = 0; gap < int'(f2); gap++) tick(1'b0, '0, took, a, w);
          tick(1'b1, f3, took, a, w);
          take_words(f4, 4, '0, '0, '0, last);
          tests++;
        end else begin
          // comment line
          code = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0 && tests > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* dv/prefetch_tests.txt */
# B target words last | L start end count target words last
# X target gap second_target first_addr_after (all fields hex)
B 00001000 8 0000101c
B 00002ff0 6 00003004
L 00004010 00004018 3 00004000 f 00004020
L 00005000 00005008 1 00005000 5 00005010
L 00006004 00006004 0 00006000 4 0000600c
L 00007008 00007008 2 00007000 5 0000700c
L 00008000 00008004 5 00008000 b 00008008
X 00001000 3 00009000 00009000
X 0000a000 0 0000b000 0000b000
X 0000c000 7 0000d100 0000d100
B 00000100 10 0000013c
L 00004010 00004018 3 00004000 f 00004020

/* flist.f */
logic/fetch_pkg.sv
logic/prefetch_ctrl.sv
logic/fetch_addr_gen.sv
logic/hwloop_unit.sv
logic/fetch_fifo.sv
logic/prefetch_top.sv
dv/prefetch_assertions.sv
dv/prefetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := prefetch_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
